// File: all.f
logic/lcd_pkg.sv
logic/lcd_byte_if.sv
logic/lcd_axil_regs.sv
logic/lcd_init_seq.sv
logic/lcd_bus_writer.sv
logic/lcd_ctrl_top.sv
tb/lcd_ctrl_checker.sv
tb/lcd_ctrl_tb.sv

// File: Bender.yml
package:
  name: lcd_ctrl

sources:
  - logic/lcd_pkg.sv
  - logic/lcd_byte_if.sv
  - logic/lcd_axil_regs.sv
  - logic/lcd_init_seq.sv
  - logic/lcd_bus_writer.sv
  - logic/lcd_ctrl_top.sv
  - target: test
    files:
      - tb/lcd_ctrl_checker.sv
      - tb/lcd_ctrl_tb.sv

// File: tb/lcd_ctrl_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_ctrl_tb import lcd_pkg::*; ();

    localparam int WAIT_LIMIT = 64;     // One AXI handshake or a few bus bytes
    localparam int INIT_LIMIT = 4000;   // Whole table with settle gaps

    logic                    iVCLK = 1'b0;
    logic                    iVRST;
    logic                    awvalid;
    logic                    awready;
    logic [AXI_ADDR_W-1:0]   awaddr;
    logic                    wvalid;
    logic                    wready;
    logic [AXI_DATA_W-1:0]   wdata;
    logic [AXI_DATA_W/8-1:0] wstrb;
    logic                    bvalid;
    logic                    bready;
    logic [1:0]              bresp;
    logic                    arvalid;
    logic                    arready;
    logic [AXI_ADDR_W-1:0]   araddr;
    logic                    rvalid;
    logic                    rready;
    logic [AXI_DATA_W-1:0]   rdata;
    logic [1:0]              rresp;
    logic [LCD_BYTE_W-1:0]   lcd_data;
    logic                    lcd_dc;
    logic                    lcd_wr_n;
    logic                    init_done;

    logic [8:0]  bus_q [$];             // {dc, data} per latched byte
    logic [16:0] lfsr_state = 17'd85168;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    lcd_ctrl_top UUT (.*);

    always #4 iVCLK = ~iVCLK;

    // Panel latches on the rising edge of the strobe
    always @(posedge lcd_wr_n) begin
        if (!iVRST)
            bus_q.push_back({lcd_dc, lcd_data});
    end

    // x^17 + x^14 + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[16] ^ lfsr_state[13];
        lfsr_state = {lfsr_state[15:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], lfsr_bit()};
        return v;
    endfunction

    task automatic next_cycle();
        @(posedge iVCLK);
        #1;
    endtask

    task automatic abort_run(input string msg);
        $display("timeout at %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic check_flag(input logic exp, input logic got, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(input logic [1:0] exp, input logic [1:0] got, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s response %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_rdata(input logic [AXI_DATA_W-1:0] exp, input logic [AXI_DATA_W-1:0] got,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bus_byte(input logic exp_dc, input logic [LCD_BYTE_W-1:0] exp_val,
                                  input logic got_dc, input logic [LCD_BYTE_W-1:0] got_val,
                                  input string what);
        if (got_dc !== exp_dc || got_val !== exp_val) begin
            errors++;
            $display("error at %0t: %s got dc %b data %h, expected dc %b data %h",
                     $time, what, got_dc, got_val, exp_dc, exp_val);
        end
    endtask

    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [AXI_DATA_W-1:0] data,
                             output logic [1:0] resp);
        int n;
        n       = 0;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge iVCLK);
        while (!awready && n < WAIT_LIMIT) begin   // Pending bytes hold the write off
            @(negedge iVCLK);
            n++;
        end
        if (!awready)
            abort_run("the write address and data were never accepted");
        check_flag(1'b1, wready, "wready together with awready");
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        n       = 0;
        @(negedge iVCLK);
        while (!bvalid && n < WAIT_LIMIT) begin
            @(negedge iVCLK);
            n++;
        end
        if (!bvalid)
            abort_run("the write response never arrived");
        resp = bresp;
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [AXI_DATA_W-1:0] data,
                            output logic [1:0] resp);
        int n;
        n       = 0;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge iVCLK);
        while (!arready && n < WAIT_LIMIT) begin
            @(negedge iVCLK);
            n++;
        end
        if (!arready)
            abort_run("the read address was never accepted");
        next_cycle();
        arvalid = 1'b0;
        rready  = 1'b1;
        n       = 0;
        @(negedge iVCLK);
        while (!rvalid && n < WAIT_LIMIT) begin
            @(negedge iVCLK);
            n++;
        end
        if (!rvalid)
            abort_run("the read data never arrived");
        data = rdata;
        resp = rresp;
        next_cycle();
        rready = 1'b0;
    endtask

    task automatic wait_bytes(input int count, input int limit);
        int n;
        n = 0;
        @(negedge iVCLK);
        while (bus_q.size() < count && n < limit) begin
            @(negedge iVCLK);
            n++;
        end
        if (bus_q.size() < count)
            abort_run("the expected bytes never appeared on the panel bus");
        next_cycle();
    endtask

    task automatic wait_init_done();
        int n;
        n = 0;
        @(negedge iVCLK);
        while (!init_done && n < INIT_LIMIT) begin
            @(negedge iVCLK);
            n++;
        end
        if (!init_done)
            abort_run("init_done never went high");
        next_cycle();
    endtask

    // Nothing may reach the bus in this window
    task automatic check_bus_quiet(input int cycles, input string what);
        repeat (cycles) next_cycle();
        if (bus_q.size() != 0) begin
            errors++;
            $display("error at %0t: %s left %0d extra bus bytes", $time, what, bus_q.size());
            bus_q.delete();
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        if (errors == err_start) begin
            tests_passed++;
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - err_start);
        end
    endtask

    task automatic test_reset();
        int                    e;
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        e = errors;
        repeat (3) begin
            next_cycle();
            check_flag(1'b1, lcd_wr_n, "lcd_wr_n in reset");
            check_flag(1'b0, init_done, "init_done in reset");
        end
        iVRST = 1'b0;
        @(negedge iVCLK);
        check_flag(1'b1, lcd_wr_n, "lcd_wr_n after reset");
        check_flag(1'b0, init_done, "init_done after reset");
        check_flag(1'b0, bvalid, "bvalid after reset");
        check_flag(1'b0, rvalid, "rvalid after reset");
        next_cycle();
        axi_read(REG_STATUS, data, resp);
        check_resp(RESP_OKAY, resp, "status read after reset");
        check_rdata('0, data, "status after reset");
        finish_test("reset state", e);
    endtask

    task automatic test_early_write();
        int           e;
        lcd_tx_word_u w;
        logic [31:0]  r;
        logic [1:0]   resp;
        logic [8:0]   got;
        e = errors;
        r = rand_bits(8);
        w = '0;
        w.byte_v.dc    = DC_DATA;
        w.byte_v.value = r[7:0];
        axi_write(REG_BYTE, w, resp);
        check_resp(RESP_OKAY, resp, "early byte write");
        wait_bytes(INIT_SIZE + 1, INIT_LIMIT);
        got = bus_q[INIT_SIZE];                 // Must follow the whole table
        bus_q.delete(INIT_SIZE);
        check_bus_byte(DC_DATA, r[7:0], got[8], got[7:0], "early host byte");
        finish_test("early host write", e);
    endtask

    task automatic test_init_sequence();
        int                    e;
        logic [8:0]            got;
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        e = errors;
        wait_bytes(INIT_SIZE, INIT_LIMIT);
        for (int i = 0; i < INIT_SIZE; i++) begin
            got = bus_q.pop_front();
            check_bus_byte(INIT_TABLE[i][8], INIT_TABLE[i][7:0], got[8], got[7:0],
                           $sformatf("init entry %0d", i));
        end
        wait_init_done();
        axi_read(REG_STATUS, data, resp);
        check_resp(RESP_OKAY, resp, "status read after init");
        check_rdata(32'd1, data, "status after init");
        check_bus_quiet(4, "init sequence");
        finish_test("init sequence", e);
    endtask

    task automatic test_byte_writes();
        int           e;
        lcd_tx_word_u w;
        logic [31:0]  r;
        logic [1:0]   resp;
        logic [8:0]   got;
        e = errors;
        for (int i = 0; i < 6; i++) begin
            r = rand_bits(8);
            w = '0;
            w.byte_v.dc    = i[0];              // Alternate command and data
            w.byte_v.value = r[7:0];
            axi_write(REG_BYTE, w, resp);
            check_resp(RESP_OKAY, resp, "byte write");
            wait_bytes(1, WAIT_LIMIT);
            got = bus_q.pop_front();
            check_bus_byte(i[0], r[7:0], got[8], got[7:0], "host byte");
        end
        check_bus_quiet(8, "byte writes");
        finish_test("byte writes", e);
    endtask

    task automatic test_pixel_writes();
        int           e;
        lcd_tx_word_u w;
        logic [31:0]  r;
        logic [15:0]  pix [4];
        logic [1:0]   resp;
        logic [8:0]   got;
        e = errors;
        for (int i = 0; i < 4; i++) begin
            r      = rand_bits(16);
            pix[i] = r[15:0];
            w      = '0;
            w.pixel_v.rgb565 = pix[i];
            axi_write(REG_PIXEL, w, resp);
            check_resp(RESP_OKAY, resp, "pixel write");
        end
        wait_bytes(8, WAIT_LIMIT);
        for (int i = 0; i < 4; i++) begin
            got = bus_q.pop_front();
            check_bus_byte(DC_DATA, pix[i][15:8], got[8], got[7:0], "pixel high byte");
            got = bus_q.pop_front();
            check_bus_byte(DC_DATA, pix[i][7:0], got[8], got[7:0], "pixel low byte");
        end
        check_bus_quiet(8, "pixel writes");
        finish_test("pixel writes", e);
    endtask

    task automatic test_decode_error();
        int                    e;
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        e = errors;
        axi_write(4'hC, 32'h0000_01A5, resp);
        check_resp(RESP_SLVERR, resp, "write to 0xC");
        axi_read(4'hC, data, resp);
        check_resp(RESP_SLVERR, resp, "read from 0xC");
        check_rdata('0, data, "read from 0xC");
        check_bus_quiet(8, "decode error");
        finish_test("decode errors", e);
    endtask

    initial begin
        iVRST   = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = 4'hF;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b0;
        test_reset();
        test_early_write();
        test_init_sequence();
        test_byte_writes();
        test_pixel_writes();
        test_decode_error();
        $display("tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests_passed, tests_failed, errors, UUT.u_bus_writer.u_checker.fail_count);
        if (errors == 0 && UUT.u_bus_writer.u_checker.fail_count == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/lcd_ctrl_checker.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_ctrl_checker import lcd_pkg::*; (
    input  wire logic                  iVCLK,
    input  wire logic                  iVRST,
    input  wire logic                  init_done,
    input  wire logic                  init_valid,
    input  wire logic                  host_ready,
    input  wire logic [LCD_BYTE_W-1:0] lcd_data,
    input  wire logic                  lcd_dc,
    input  wire logic                  lcd_wr_n
);

    int fail_count = 0;

    // Strobe is a single-cycle pulse
    single_strobe: assert property (@(posedge iVCLK) disable iff (iVRST)
        !lcd_wr_n |=> lcd_wr_n)
        else begin
            fail_count++;
            $error("lcd_wr_n low for two cycles in a row");
        end

    pins_stable: assert property (@(posedge iVCLK) disable iff (iVRST)
        !lcd_wr_n |=> ($stable(lcd_data) && $stable(lcd_dc)))   // Held across latch edge
        else begin
            fail_count++;
            $error("lcd_data or lcd_dc changed around the strobe");
        end

    one_source: assert property (@(posedge iVCLK) disable iff (iVRST)
        init_done |-> !(init_valid && host_ready))
        else begin
            fail_count++;
            $error("init stream active while host stream served");
        end

endmodule

bind lcd_bus_writer lcd_ctrl_checker u_checker (
    .iVCLK      (iVCLK),
    .iVRST      (iVRST),
    .init_done  (init_done),
    .init_valid (init_bytes.valid),
    .host_ready (host_bytes.ready),
    .lcd_data   (lcd_data),
    .lcd_dc     (lcd_dc),
    .lcd_wr_n   (lcd_wr_n)
);

`default_nettype wire

// File: logic/lcd_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_ctrl_top import lcd_pkg::*; (
    input  wire logic                    iVCLK,
    input  wire logic                    iVRST,
    input  wire logic                    awvalid,
    output logic                         awready,
    input  wire logic [AXI_ADDR_W-1:0]   awaddr,
    input  wire logic                    wvalid,
    output logic                         wready,
    input  wire logic [AXI_DATA_W-1:0]   wdata,
    input  wire logic [AXI_DATA_W/8-1:0] wstrb,
    output logic                         bvalid,
    input  wire logic                    bready,
    output logic [1:0]                   bresp,
    input  wire logic                    arvalid,
    output logic                         arready,
    input  wire logic [AXI_ADDR_W-1:0]   araddr,
    output logic                         rvalid,
    input  wire logic                    rready,
    output logic [AXI_DATA_W-1:0]        rdata,
    output logic [1:0]                   rresp,
    output logic [LCD_BYTE_W-1:0]        lcd_data,
    output logic                         lcd_dc,
    output logic                         lcd_wr_n,
    output logic                         init_done
);

    lcd_byte_if init_bytes ();
    lcd_byte_if host_bytes ();

    lcd_axil_regs u_regs (
        .iVCLK      (iVCLK),
        .iVRST      (iVRST),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .init_done  (init_done),
        .host_bytes (host_bytes.src)
    );

    lcd_init_seq u_init_seq (
        .iVCLK      (iVCLK),
        .iVRST      (iVRST),
        .init_bytes (init_bytes.src),
        .init_done  (init_done)
    );

    lcd_bus_writer u_bus_writer (
        .iVCLK      (iVCLK),
        .iVRST      (iVRST),
        .init_done  (init_done),
        .init_bytes (init_bytes.dst),
        .host_bytes (host_bytes.dst),
        .lcd_data   (lcd_data),
        .lcd_dc     (lcd_dc),
        .lcd_wr_n   (lcd_wr_n)
    );

endmodule

`default_nettype wire

// File: logic/lcd_bus_writer.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_bus_writer import lcd_pkg::*; (
    input  wire logic              iVCLK,
    input  wire logic              iVRST,
    input  wire logic              init_done,
    lcd_byte_if.dst                init_bytes,
    lcd_byte_if.dst                host_bytes,
    output logic [LCD_BYTE_W-1:0]  lcd_data,
    output logic                   lcd_dc,
    output logic                   lcd_wr_n
);

    logic [1:0]            state;
    logic                  idle;
    logic                  take;
    logic                  sel_dc;
    logic [LCD_BYTE_W-1:0] sel_data;

    assign idle = (state == WR_IDLE);

    // Host stream waits for the init table to finish
    assign init_bytes.ready = idle && !init_done;
    assign host_bytes.ready = idle && init_done;

    assign take     = init_done ? (host_bytes.valid && host_bytes.ready)
                                : (init_bytes.valid && init_bytes.ready);
    assign sel_dc   = init_done ? host_bytes.dc : init_bytes.dc;
    assign sel_data = init_done ? host_bytes.data : init_bytes.data;

    always_ff @(posedge iVCLK) begin
        if (iVRST) begin
            state    <= WR_IDLE;
            lcd_wr_n <= 1'b1;
            lcd_dc   <= 1'b0;
            lcd_data <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (take) begin
                        state    <= WR_STROBE;
                        lcd_wr_n <= 1'b0;   // Pins and strobe together
                        lcd_dc   <= sel_dc;
                        lcd_data <= sel_data;
                    end
                end
                WR_STROBE: begin
                    state    <= WR_HOLD;
                    lcd_wr_n <= 1'b1;       // Panel latches on this edge
                end
                WR_HOLD: begin
                    state <= WR_IDLE;       // Hold cycle after the rising edge
                end
                default: begin
                    state    <= WR_IDLE;
                    lcd_wr_n <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/lcd_init_seq.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_init_seq import lcd_pkg::*; (
    input  wire logic iVCLK,
    input  wire logic iVRST,
    lcd_byte_if.src   init_bytes,
    output logic      init_done
);

    logic [INIT_IDX_W-1:0] idx;
    logic [SETTLE_W-1:0]   settle_cnt;
    logic                  settling;
    logic                  last_entry;

    assign last_entry = (idx == INIT_IDX_W'(INIT_SIZE - 1));

    // Entry held steady until the writer takes it
    assign init_bytes.valid = !settling && !init_done;
    assign init_bytes.dc    = INIT_TABLE[idx][8];
    assign init_bytes.data  = INIT_TABLE[idx][7:0];

    always_ff @(posedge iVCLK) begin
        if (iVRST) begin
            idx        <= '0;
            settle_cnt <= '0;
            settling   <= 1'b0;
            init_done  <= 1'b0;
        end else if (settling) begin
            if (settle_cnt == '0) begin
                settling <= 1'b0;
                if (last_entry)
                    init_done <= 1'b1;          // Sticky until reset
                else
                    idx <= idx + 1'b1;
            end else begin
                settle_cnt <= settle_cnt - 1'b1;
            end
        end else if (init_bytes.valid && init_bytes.ready) begin
            settling   <= 1'b1;
            settle_cnt <= SETTLE_W'(SETTLE_CYCLES - 1);
        end
    end

endmodule

`default_nettype wire

// File: logic/lcd_axil_regs.sv
`timescale 1ns/10ps
`default_nettype none

module lcd_axil_regs import lcd_pkg::*; (
    input  wire logic                    iVCLK,
    input  wire logic                    iVRST,
    input  wire logic                    awvalid,
    output logic                         awready,
    input  wire logic [AXI_ADDR_W-1:0]   awaddr,
    input  wire logic                    wvalid,
    output logic                         wready,
    input  wire logic [AXI_DATA_W-1:0]   wdata,
    input  wire logic [AXI_DATA_W/8-1:0] wstrb,    // Full-word writes only
    output logic                         bvalid,
    input  wire logic                    bready,
    output logic [1:0]                   bresp,
    input  wire logic                    arvalid,
    output logic                         arready,
    input  wire logic [AXI_ADDR_W-1:0]   araddr,
    output logic                         rvalid,
    input  wire logic                    rready,
    output logic [AXI_DATA_W-1:0]        rdata,
    output logic [1:0]                   rresp,
    input  wire logic                    init_done,
    lcd_byte_if.src                      host_bytes
);

    lcd_tx_word_u          tx_word;
    logic                  wr_take;
    logic                  wr_byte;
    logic                  wr_pixel;
    logic                  rd_take;
    logic                  host_hs;
    logic                  tx_pending;
    logic [1:0]            q_vld;      // Slot 0 offered while slot 1 waits
    logic [1:0]            q_dc;
    logic [LCD_BYTE_W-1:0] q_data [2];

    assign tx_word  = wdata;
    assign wr_byte  = (awaddr == REG_BYTE);
    assign wr_pixel = (awaddr == REG_PIXEL);
    assign wr_take  = awvalid && wvalid && !tx_pending && !bvalid;
    assign awready  = wr_take;
    assign wready   = wr_take;
    assign arready  = !rvalid;
    assign rd_take  = arvalid && !rvalid;

    assign tx_pending       = |q_vld;
    assign host_bytes.valid = q_vld[0];
    assign host_bytes.dc    = q_dc[0];
    assign host_bytes.data  = q_data[0];
    assign host_hs          = host_bytes.valid && host_bytes.ready;

    always_ff @(posedge iVCLK) begin
        if (iVRST) begin
            q_vld  <= 2'b00;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_take) begin
                bvalid <= 1'b1;
                if (wr_byte)
                    q_vld <= 2'b01;
                else if (wr_pixel)
                    q_vld <= 2'b11;             // High byte then low byte
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (host_hs)
                q_vld <= {1'b0, q_vld[1]};      // Queue is empty whenever wr_take is high
            if (rd_take)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge iVCLK) begin
        if (wr_take) begin
            bresp <= (wr_byte || wr_pixel) ? RESP_OKAY : RESP_SLVERR;
            if (wr_byte) begin
                q_dc[0]   <= tx_word.byte_v.dc;
                q_data[0] <= tx_word.byte_v.value;
            end else if (wr_pixel) begin
                q_dc      <= {DC_DATA, DC_DATA};
                q_data[0] <= tx_word.pixel_v.rgb565[15:8];
                q_data[1] <= tx_word.pixel_v.rgb565[7:0];
            end
        end else if (host_hs) begin
            q_dc[0]   <= q_dc[1];
            q_data[0] <= q_data[1];
        end
        if (rd_take) begin
            if (araddr == REG_STATUS) begin
                rdata <= {{(AXI_DATA_W-2){1'b0}}, tx_pending, init_done};
                rresp <= RESP_OKAY;
            end else begin
                rdata <= '0;
                rresp <= RESP_SLVERR;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/lcd_byte_if.sv
`timescale 1ns/10ps
`default_nettype none

interface lcd_byte_if import lcd_pkg::*; ();

    logic                  valid;
    logic                  ready;
    logic                  dc;      // 0 command, 1 data
    logic [LCD_BYTE_W-1:0] data;

    modport src (
        output valid,
        output dc,
        output data,
        input  ready
    );

    modport dst (
        input  valid,
        input  dc,
        input  data,
        output ready
    );

endinterface

`default_nettype wire

// File: logic/lcd_pkg.sv
`default_nettype none

package lcd_pkg;

    // Bus widths
    localparam int LCD_BYTE_W = 8;
    localparam int AXI_ADDR_W = 4;
    localparam int AXI_DATA_W = 32;

    // DC pin levels
    localparam logic DC_CMD  = 1'b0;
    localparam logic DC_DATA = 1'b1;

    // ILI9341 command codes used by the init table
    localparam logic [7:0] CMD_SW_RESET     = 8'h01;
    localparam logic [7:0] CMD_SLEEP_OUT    = 8'h11;
    localparam logic [7:0] CMD_GAMMA_SET    = 8'h26;
    localparam logic [7:0] CMD_DISP_OFF     = 8'h28;
    localparam logic [7:0] CMD_DISP_ON      = 8'h29;
    localparam logic [7:0] CMD_COL_ADDR     = 8'h2A;
    localparam logic [7:0] CMD_PAGE_ADDR    = 8'h2B;
    localparam logic [7:0] CMD_MEM_WRITE    = 8'h2C;
    localparam logic [7:0] CMD_MEM_ACCESS   = 8'h36;
    localparam logic [7:0] CMD_PIXEL_FORMAT = 8'h3A;
    localparam logic [7:0] CMD_RGB_IF_CTRL  = 8'hB0;
    localparam logic [7:0] CMD_FRAME_CTRL   = 8'hB1;
    localparam logic [7:0] CMD_BLANK_PORCH  = 8'hB5;
    localparam logic [7:0] CMD_DISP_FUNC    = 8'hB6;
    localparam logic [7:0] CMD_PWR_CTRL1    = 8'hC0;
    localparam logic [7:0] CMD_PWR_CTRL2    = 8'hC1;
    localparam logic [7:0] CMD_VCOM_CTRL1   = 8'hC5;
    localparam logic [7:0] CMD_VCOM_CTRL2   = 8'hC7;
    localparam logic [7:0] CMD_POS_GAMMA    = 8'hE0;
    localparam logic [7:0] CMD_NEG_GAMMA    = 8'hE1;
    localparam logic [7:0] CMD_IF_CTRL      = 8'hF6;

    // Interface setup values
    localparam logic [7:0] PIX_RGB18     = 8'h66;
    localparam logic [7:0] IF_MODE_RGB   = 8'h06;
    localparam logic [7:0] RGB_IF_SELECT = 8'h40;

    // Init table with DC in bit 8
    localparam int INIT_SIZE  = 71;
    localparam int INIT_IDX_W = $clog2(INIT_SIZE);

    localparam logic [8:0] INIT_TABLE [INIT_SIZE] = '{
        {DC_CMD,  CMD_SW_RESET},
        {DC_CMD,  CMD_DISP_OFF},
        {DC_CMD,  CMD_PIXEL_FORMAT},
        {DC_DATA, PIX_RGB18},
        {DC_CMD,  CMD_PWR_CTRL1},
        {DC_DATA, 8'h01},
        {DC_CMD,  CMD_PWR_CTRL2},
        {DC_DATA, 8'h00},
        {DC_CMD,  CMD_VCOM_CTRL1},
        {DC_DATA, 8'h3E}, {DC_DATA, 8'h28},
        {DC_CMD,  CMD_VCOM_CTRL2},
        {DC_DATA, 8'h86},
        {DC_CMD,  CMD_MEM_ACCESS},
        {DC_DATA, 8'h14},
        {DC_CMD,  CMD_FRAME_CTRL},
        {DC_DATA, 8'h00}, {DC_DATA, 8'h1F},
        {DC_CMD,  CMD_DISP_FUNC},
        {DC_DATA, 8'h0A}, {DC_DATA, 8'hA2}, {DC_DATA, 8'h27}, {DC_DATA, 8'h04},
        {DC_CMD,  CMD_GAMMA_SET},
        {DC_DATA, 8'h01},
        {DC_CMD,  CMD_POS_GAMMA},
        {DC_DATA, 8'h0F}, {DC_DATA, 8'h31}, {DC_DATA, 8'h2B}, {DC_DATA, 8'h0C},
        {DC_DATA, 8'h0E}, {DC_DATA, 8'h10}, {DC_DATA, 8'h03}, {DC_DATA, 8'h0E},
        {DC_DATA, 8'h09}, {DC_DATA, 8'h00},
        {DC_CMD,  CMD_NEG_GAMMA},
        {DC_DATA, 8'h00}, {DC_DATA, 8'h0E}, {DC_DATA, 8'h14}, {DC_DATA, 8'h03},
        {DC_DATA, 8'h11}, {DC_DATA, 8'h0F}, {DC_DATA, 8'h0C}, {DC_DATA, 8'h31},
        {DC_DATA, 8'h36}, {DC_DATA, 8'h0F},
        {DC_CMD,  CMD_IF_CTRL},
        {DC_DATA, 8'h01}, {DC_DATA, 8'h10}, {DC_DATA, IF_MODE_RGB},
        {DC_CMD,  CMD_RGB_IF_CTRL},
        {DC_DATA, RGB_IF_SELECT},
        {DC_CMD,  CMD_BLANK_PORCH},
        {DC_DATA, 8'h04},                   // VFP
        {DC_DATA, 8'h02},                   // VBP
        {DC_DATA, 8'h10},                   // HFP
        {DC_DATA, 8'h18},                   // HBP
        {DC_CMD,  CMD_COL_ADDR},
        {DC_DATA, 8'h00}, {DC_DATA, 8'h00}, {DC_DATA, 8'h00}, {DC_DATA, 8'hF0},
        {DC_CMD,  CMD_PAGE_ADDR},
        {DC_DATA, 8'h00}, {DC_DATA, 8'h00}, {DC_DATA, 8'h01}, {DC_DATA, 8'h40},
        {DC_CMD,  CMD_SLEEP_OUT},
        {DC_CMD,  CMD_DISP_ON},
        {DC_CMD,  CMD_MEM_WRITE}            // Leaves panel ready for pixels
    };

    // Idle cycles after each table entry
    localparam int SETTLE_CYCLES = 16;  // Raised for silicon
    localparam int SETTLE_W      = $clog2(SETTLE_CYCLES + 1);

    // Bus writer strobe states
    localparam logic [1:0] WR_IDLE   = 2'd0;
    localparam logic [1:0] WR_STROBE = 2'd1;
    localparam logic [1:0] WR_HOLD   = 2'd2;

    // Register map
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 4'h0;
    localparam logic [AXI_ADDR_W-1:0] REG_BYTE   = 4'h4;
    localparam logic [AXI_ADDR_W-1:0] REG_PIXEL  = 4'h8;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Write word whose view follows the register address
    typedef union packed {
        struct packed {
            logic [22:0] rsvd;
            logic        dc;
            logic [7:0]  value;
        } byte_v;
        struct packed {
            logic [15:0] rsvd;
            logic [15:0] rgb565;
        } pixel_v;
    } lcd_tx_word_u;

endpackage

`default_nettype wire
